// ==== design/button_edge.sv ====
`timescale 1ns/100ps

module button_edge (
    input  logic clk,
    input  logic rst_n,
    input  logic confirm,
    input  logic select,
    input  logic exit,
    input  logic review,
    output logic confirm_press,
    output logic select_press,
    output logic exit_press,
    output logic review_press
);

    logic [3:0] sync1;                                  // first metastability stage
    logic [3:0] sync2;
    logic [3:0] prev;                                   // last synchronized level
    logic [3:0] press_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1   <= '0;
            sync2   <= '0;
            prev    <= '0;
            press_q <= '0;
        end else begin
            sync1   <= {review, exit, select, confirm};
            sync2   <= sync1;
            prev    <= sync2;
            press_q <= sync2 & ~prev;                   // rising edge only
        end
    end

    assign confirm_press = press_q[0];
    assign select_press  = press_q[1];
    assign exit_press    = press_q[2];
    assign review_press  = press_q[3];

endmodule

// ==== design/display_scan.sv ====
`timescale 1ns/100ps

module display_scan #(
    parameter int scan_div = quiz_pkg::scan_div_default
) (
    input  logic             clk,
    input  logic             rst_n,
    input  quiz_pkg::glyph_t digit0,
    input  quiz_pkg::glyph_t digit1,
    input  quiz_pkg::glyph_t digit2,
    input  quiz_pkg::glyph_t digit3,
    output quiz_pkg::glyph_t seg,
    output logic [3:0]       anode
);

    localparam int div_w = $clog2(scan_div + 1);

    logic [div_w-1:0] div_cnt;                          // clocks spent in current slot
    logic [1:0]       slot;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            slot    <= '0;
        end else if (div_cnt == div_w'(scan_div - 1)) begin
            div_cnt <= '0;
            slot    <= slot + 2'd1;                     // wraps 3 -> 0
        end else begin
            div_cnt <= div_cnt + div_w'(1);
        end
    end

    assign anode = 4'b0001 << slot;

    always_comb begin
        case (slot)
            2'd0:    seg = digit0;
            2'd1:    seg = digit1;
            2'd2:    seg = digit2;
            default: seg = digit3;
        endcase
    end

endmodule

// ==== design/entry_control.sv ====
`timescale 1ns/100ps

module entry_control (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   confirm_press,
    input  logic                   select_press,
    input  logic                   exit_press,
    input  logic                   review_press,
    input  quiz_pkg::operand_t     sw,
    output logic                   wr_en,
    output quiz_pkg::mode_t        wr_mode,
    output quiz_pkg::op_idx_t      wr_op,
    output quiz_pkg::operand_t     wr_a,
    output quiz_pkg::operand_t     wr_b,
    output quiz_pkg::count_t       rd_num,
    output quiz_pkg::mode_t        cur_mode,
    output quiz_pkg::op_idx_t      cur_op,
    output logic                   entered,
    output quiz_pkg::entry_step_t  step,
    output logic                   review_on,
    output quiz_pkg::review_step_t rev_step
);

    logic entry_confirm;                                // confirm that reaches the entry steps
    logic take_a;
    logic take_b;

    // highest operator index of a mode
    function automatic logic [2:0] op_last(input quiz_pkg::mode_t m);
        case (m)
            quiz_pkg::mode_1: return 3'(quiz_pkg::op_count_m1 - 1);
            quiz_pkg::mode_2: return 3'(quiz_pkg::op_count_m2 - 1);
            default:          return 3'(quiz_pkg::op_count_wide - 1);
        endcase
    endfunction

    function automatic quiz_pkg::mode_t next_mode(input quiz_pkg::mode_t m);
        case (m)
            quiz_pkg::mode_1: return quiz_pkg::mode_2;
            quiz_pkg::mode_2: return quiz_pkg::mode_3;
            quiz_pkg::mode_3: return quiz_pkg::mode_4;
            quiz_pkg::mode_4: return quiz_pkg::mode_5;
            default:          return quiz_pkg::mode_1;
        endcase
    endfunction

    // exit and select win over confirm while entered
    assign entry_confirm = entered & ~review_on & confirm_press & ~exit_press & ~select_press;
    assign take_a        = entry_confirm & (step == quiz_pkg::step_a);
    assign take_b        = entry_confirm & (step == quiz_pkg::step_b);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_mode  <= quiz_pkg::mode_1;
            cur_op    <= '0;
            entered   <= 1'b0;
            step      <= quiz_pkg::step_idle;
            review_on <= 1'b0;
            rev_step  <= quiz_pkg::rev_prompt;
            rd_num    <= '0;
            wr_en     <= 1'b0;
        end else begin
            wr_en <= 1'b0;                              // single-cycle write strobe
            if (review_on) begin
                if (review_press) begin
                    review_on <= 1'b0;
                end else if (confirm_press) begin
                    if (rev_step == quiz_pkg::rev_prompt) begin
                        rd_num   <= quiz_pkg::count_t'(sw);   // 1-based question number
                        rev_step <= quiz_pkg::rev_show;
                    end else begin
                        rev_step <= quiz_pkg::rev_prompt;
                    end
                end
            end else if (entered) begin
                if (exit_press) begin
                    entered <= 1'b0;
                    step    <= quiz_pkg::step_idle;
                end else if (select_press) begin
                    if (3'(cur_op) == op_last(cur_mode))
                        cur_op <= '0;
                    else
                        cur_op <= cur_op + 2'd1;
                end else if (confirm_press) begin
                    case (step)
                        quiz_pkg::step_idle: step <= quiz_pkg::step_a;
                        quiz_pkg::step_a: begin
                            if (cur_mode == quiz_pkg::mode_1) begin
                                wr_en <= 1'b1;          // radix mode has no operand b
                                step  <= quiz_pkg::step_idle;
                            end else begin
                                step  <= quiz_pkg::step_b;
                            end
                        end
                        quiz_pkg::step_b: begin
                            wr_en <= 1'b1;
                            step  <= quiz_pkg::step_idle;
                        end
                        default: step <= quiz_pkg::step_idle;
                    endcase
                end
            end else begin
                if (review_press) begin
                    review_on <= 1'b1;
                    rev_step  <= quiz_pkg::rev_prompt;  // prompt first
                end else if (select_press) begin
                    cur_mode <= next_mode(cur_mode);
                end else if (confirm_press) begin
                    entered <= 1'b1;
                    cur_op  <= '0;
                    step    <= quiz_pkg::step_idle;
                end
            end
        end
    end

    // record payload, wr_a doubles as the operand a latch
    always_ff @(posedge clk) begin
        if (take_a) begin
            wr_a    <= sw;
            wr_b    <= '0;
            wr_mode <= cur_mode;
            wr_op   <= cur_op;
        end
        if (take_b) begin
            wr_b    <= sw;
            wr_mode <= cur_mode;
            wr_op   <= cur_op;
        end
    end

endmodule

// ==== design/glyph_encoder.sv ====
`timescale 1ns/100ps

module glyph_encoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  quiz_pkg::mode_t        cur_mode,
    input  quiz_pkg::op_idx_t      cur_op,
    input  logic                   entered,
    input  logic                   review_on,
    input  quiz_pkg::entry_step_t  step,
    input  quiz_pkg::review_step_t rev_step,
    input  logic                   rd_valid,
    input  quiz_pkg::mode_t        rd_mode,
    input  quiz_pkg::op_idx_t      rd_op,
    input  quiz_pkg::operand_t     rd_a,
    input  quiz_pkg::operand_t     rd_b,
    output quiz_pkg::glyph_t       digit0,
    output quiz_pkg::glyph_t       digit1,
    output quiz_pkg::glyph_t       digit2,
    output quiz_pkg::glyph_t       digit3,
    output quiz_pkg::operand_t     led_a,
    output quiz_pkg::operand_t     led_b
);

    quiz_pkg::glyph_t   d0_nx, d1_nx, d2_nx, d3_nx;
    quiz_pkg::operand_t la_nx, lb_nx;

    function automatic quiz_pkg::glyph_t mode_glyph(input quiz_pkg::mode_t m);
        case (m)
            quiz_pkg::mode_1: return quiz_pkg::glyph_digit_1;
            quiz_pkg::mode_2: return quiz_pkg::glyph_digit_2;
            quiz_pkg::mode_3: return quiz_pkg::glyph_digit_3;
            quiz_pkg::mode_4: return quiz_pkg::glyph_digit_4;
            quiz_pkg::mode_5: return quiz_pkg::glyph_digit_5;
            default:          return quiz_pkg::glyph_blank;
        endcase
    endfunction

    // op index shown as op+1
    function automatic quiz_pkg::glyph_t op_num_glyph(input quiz_pkg::op_idx_t op);
        case (op)
            2'd0:    return quiz_pkg::glyph_digit_1;
            2'd1:    return quiz_pkg::glyph_digit_2;
            2'd2:    return quiz_pkg::glyph_digit_3;
            default: return quiz_pkg::glyph_digit_4;
        endcase
    endfunction

    function automatic quiz_pkg::glyph_t radix_glyph(input quiz_pkg::op_idx_t op);
        case (op)
            2'd0:    return quiz_pkg::glyph_b;
            2'd1:    return quiz_pkg::glyph_o;
            2'd2:    return quiz_pkg::glyph_h;
            default: return quiz_pkg::glyph_blank;
        endcase
    endfunction

    always_comb begin
        d0_nx = quiz_pkg::glyph_blank;
        d1_nx = quiz_pkg::glyph_blank;
        d2_nx = quiz_pkg::glyph_blank;
        d3_nx = quiz_pkg::glyph_blank;
        la_nx = '0;
        lb_nx = '0;
        if (review_on) begin
            if (rev_step == quiz_pkg::rev_prompt) begin
                d1_nx = quiz_pkg::glyph_n;              // ask for question number
            end else if (rd_valid) begin
                d0_nx = mode_glyph(rd_mode);
                d1_nx = (rd_mode == quiz_pkg::mode_1) ? radix_glyph(rd_op) : op_num_glyph(rd_op);
                la_nx = rd_a;
                lb_nx = rd_b;
            end
        end else if (entered) begin
            d0_nx = mode_glyph(cur_mode);
            d1_nx = op_num_glyph(cur_op);
            if (step != quiz_pkg::step_idle)
                d2_nx = quiz_pkg::glyph_a;
            if (step == quiz_pkg::step_b)
                d3_nx = quiz_pkg::glyph_b;
        end else begin
            d0_nx = mode_glyph(cur_mode);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digit0 <= quiz_pkg::glyph_blank;
            digit1 <= quiz_pkg::glyph_blank;
            digit2 <= quiz_pkg::glyph_blank;
            digit3 <= quiz_pkg::glyph_blank;
            led_a  <= '0;
            led_b  <= '0;
        end else begin
            digit0 <= d0_nx;
            digit1 <= d1_nx;
            digit2 <= d2_nx;
            digit3 <= d3_nx;
            led_a  <= la_nx;
            led_b  <= lb_nx;
        end
    end

endmodule

// ==== design/question_bank.sv ====
`timescale 1ns/100ps

module question_bank (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  quiz_pkg::mode_t    wr_mode,
    input  quiz_pkg::op_idx_t  wr_op,
    input  quiz_pkg::operand_t wr_a,
    input  quiz_pkg::operand_t wr_b,
    input  quiz_pkg::count_t   rd_num,
    output logic               rd_valid,
    output quiz_pkg::mode_t    rd_mode,
    output quiz_pkg::op_idx_t  rd_op,
    output quiz_pkg::operand_t rd_a,
    output quiz_pkg::operand_t rd_b
);

    quiz_pkg::mode_t    mem_mode [quiz_pkg::bank_depth];
    quiz_pkg::op_idx_t  mem_op   [quiz_pkg::bank_depth];
    quiz_pkg::operand_t mem_a    [quiz_pkg::bank_depth];
    quiz_pkg::operand_t mem_b    [quiz_pkg::bank_depth];

    quiz_pkg::count_t     count;                        // records stored so far
    quiz_pkg::bank_addr_t rd_addr;
    logic                 bank_full;

    assign bank_full = (count >= quiz_pkg::count_t'(quiz_pkg::bank_depth));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            count <= '0;
        else if (wr_en && !bank_full)
            count <= count + quiz_pkg::count_t'(1);
    end

    always_ff @(posedge clk) begin
        if (wr_en && !bank_full) begin
            mem_mode[quiz_pkg::bank_addr_t'(count)] <= wr_mode;
            mem_op[quiz_pkg::bank_addr_t'(count)]   <= wr_op;
            mem_a[quiz_pkg::bank_addr_t'(count)]    <= wr_a;
            mem_b[quiz_pkg::bank_addr_t'(count)]    <= wr_b;
        end
    end

    assign rd_valid = (rd_num != '0) && (rd_num <= count);
    assign rd_addr  = rd_valid ? quiz_pkg::bank_addr_t'(rd_num - quiz_pkg::count_t'(1)) : '0;

    assign rd_mode = mem_mode[rd_addr];
    assign rd_op   = mem_op[rd_addr];
    assign rd_a    = mem_a[rd_addr];
    assign rd_b    = mem_b[rd_addr];

endmodule

// ==== design/quiz_entry_top.sv ====
`timescale 1ns/100ps

module quiz_entry_top #(
    parameter int scan_div = quiz_pkg::scan_div_default
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               confirm,
    input  logic               select,
    input  logic               exit,
    input  logic               review,
    input  quiz_pkg::operand_t sw,
    output quiz_pkg::glyph_t   seg,
    output logic [3:0]         anode,
    output quiz_pkg::operand_t led_a,
    output quiz_pkg::operand_t led_b
);

    logic confirm_press, select_press, exit_press, review_press;

    // bank write and read
    logic                   wr_en;
    quiz_pkg::mode_t        wr_mode;
    quiz_pkg::op_idx_t      wr_op;
    quiz_pkg::operand_t     wr_a, wr_b;
    quiz_pkg::count_t       rd_num;
    logic                   rd_valid;
    quiz_pkg::mode_t        rd_mode;
    quiz_pkg::op_idx_t      rd_op;
    quiz_pkg::operand_t     rd_a, rd_b;

    // control view for the display
    quiz_pkg::mode_t        cur_mode;
    quiz_pkg::op_idx_t      cur_op;
    logic                   entered;
    quiz_pkg::entry_step_t  step;
    logic                   review_on;
    quiz_pkg::review_step_t rev_step;

    quiz_pkg::glyph_t digit0, digit1, digit2, digit3;

    button_edge u_button_edge (
        .clk(clk), .rst_n(rst_n),
        .confirm(confirm), .select(select), .exit(exit), .review(review),
        .confirm_press(confirm_press), .select_press(select_press),
        .exit_press(exit_press), .review_press(review_press)
    );

    entry_control u_control (
        .clk(clk), .rst_n(rst_n),
        .confirm_press(confirm_press), .select_press(select_press),
        .exit_press(exit_press), .review_press(review_press), .sw(sw),
        .wr_en(wr_en), .wr_mode(wr_mode), .wr_op(wr_op), .wr_a(wr_a), .wr_b(wr_b),
        .rd_num(rd_num), .cur_mode(cur_mode), .cur_op(cur_op), .entered(entered),
        .step(step), .review_on(review_on), .rev_step(rev_step)
    );

    question_bank u_bank (
        .clk(clk), .rst_n(rst_n),
        .wr_en(wr_en), .wr_mode(wr_mode), .wr_op(wr_op), .wr_a(wr_a), .wr_b(wr_b),
        .rd_num(rd_num), .rd_valid(rd_valid), .rd_mode(rd_mode), .rd_op(rd_op),
        .rd_a(rd_a), .rd_b(rd_b)
    );

    glyph_encoder u_encoder (
        .clk(clk), .rst_n(rst_n),
        .cur_mode(cur_mode), .cur_op(cur_op), .entered(entered), .review_on(review_on),
        .step(step), .rev_step(rev_step), .rd_valid(rd_valid), .rd_mode(rd_mode),
        .rd_op(rd_op), .rd_a(rd_a), .rd_b(rd_b),
        .digit0(digit0), .digit1(digit1), .digit2(digit2), .digit3(digit3),
        .led_a(led_a), .led_b(led_b)
    );

    display_scan #(.scan_div(scan_div)) u_scan (
        .clk(clk), .rst_n(rst_n),
        .digit0(digit0), .digit1(digit1), .digit2(digit2), .digit3(digit3),
        .seg(seg), .anode(anode)
    );

endmodule

// ==== design/quiz_pkg.sv ====
package quiz_pkg;

    localparam int mode_w    = 5;
    localparam int op_w      = 2;
    localparam int operand_w = 8;
    localparam int glyph_w   = 8;
    localparam int addr_w    = 6;
    localparam int count_w   = 8;

    localparam int bank_depth = 50;                    // records in the question bank

    // operators per mode
    localparam int op_count_m1   = 3;                  // radix b / o / h
    localparam int op_count_m2   = 2;                  // signed add / sub
    localparam int op_count_wide = 4;                  // modes 3 to 5

    localparam int scan_div_default = 10000;           // clocks per digit slot on the board

    typedef enum logic [mode_w-1:0] {
        mode_1 = 5'b00001,
        mode_2 = 5'b00010,
        mode_3 = 5'b00100,
        mode_4 = 5'b01000,
        mode_5 = 5'b10000
    } mode_t;

    typedef logic [op_w-1:0]      op_idx_t;
    typedef logic [operand_w-1:0] operand_t;
    typedef logic [glyph_w-1:0]   glyph_t;
    typedef logic [addr_w-1:0]    bank_addr_t;
    typedef logic [count_w-1:0]   count_t;

    typedef enum logic [1:0] {
        step_idle,
        step_a,
        step_b
    } entry_step_t;

    typedef enum logic {
        rev_prompt,
        rev_show
    } review_step_t;

    // segment patterns, bit 7 = seg a ... bit 0 = dp
    localparam glyph_t glyph_digit_1 = 8'b0110_0000;
    localparam glyph_t glyph_digit_2 = 8'b1101_1010;
    localparam glyph_t glyph_digit_3 = 8'b1111_0010;
    localparam glyph_t glyph_digit_4 = 8'b0110_0110;
    localparam glyph_t glyph_digit_5 = 8'b1011_0110;
    localparam glyph_t glyph_a       = 8'b1110_1110;
    localparam glyph_t glyph_b       = 8'b0011_1110;
    localparam glyph_t glyph_n       = 8'b1110_1100;
    localparam glyph_t glyph_o       = 8'b0011_1010;
    localparam glyph_t glyph_h       = 8'b0010_1110;
    localparam glyph_t glyph_blank   = 8'b0000_0000;

endpackage

// ==== files.f ====
design/quiz_pkg.sv
design/button_edge.sv
design/entry_control.sv
design/question_bank.sv
design/glyph_encoder.sv
design/display_scan.sv
design/quiz_entry_top.sv
testbench/quiz_entry_assertions.sv
testbench/tb_quiz_entry.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timing --top-module tb_quiz_entry -f files.f -o sim_quiz \
    && ./obj_dir/sim_quiz +verilator+error+limit+100 2>&1 | tee sim.log \
    || { echo "build or run did not complete"; exit 1; }
grep -q "Simulation FAILED" sim.log && { echo "run failed, see sim.log"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "no verdict in sim.log"; exit 1; }
echo "run passed"

// ==== testbench/quiz_entry_assertions.sv ====
`timescale 1ns/100ps

module quiz_entry_assertions (
    input logic             clk,
    input logic             rst_n,
    input logic [3:0]       anode,
    input logic [3:0]       press,                      // review, exit, select, confirm
    input logic             wr_en,
    input logic             review_on,
    input quiz_pkg::count_t count
);

    int fail_cnt = 0;                                   // failed assertions so far

    assert property (@(posedge clk) disable iff (!rst_n) $onehot(anode))
        else begin
            fail_cnt++;
            $error("anode is not one-hot: %b", anode);
        end

    // each press acts for a single cycle
    assert property (@(posedge clk) disable iff (!rst_n) (press & $past(press)) == 4'b0000)
        else begin
            fail_cnt++;
            $error("press pulse high on two consecutive cycles: %b", press);
        end

    assert property (@(posedge clk) disable iff (!rst_n)
                     count <= quiz_pkg::count_t'(quiz_pkg::bank_depth))
        else begin
            fail_cnt++;
            $error("bank count %0d exceeds bank depth", count);
        end

    assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !review_on)
        else begin
            fail_cnt++;
            $error("bank write while review is on");
        end

endmodule

bind quiz_entry_top quiz_entry_assertions u_assertions (
    .clk(clk), .rst_n(rst_n), .anode(anode),
    .press({review_press, exit_press, select_press, confirm_press}),
    .wr_en(wr_en), .review_on(review_on), .count(u_bank.count)
);

// ==== testbench/tb_quiz_entry.sv ====
`timescale 1ns/100ps

module tb_quiz_entry;

    localparam int max_cycles  = 20000;                 // cycle budget for the whole run
    localparam int btn_confirm = 0;
    localparam int btn_select  = 1;
    localparam int btn_exit    = 2;
    localparam int btn_review  = 3;
    localparam quiz_pkg::glyph_t blank = quiz_pkg::glyph_blank;

    logic               clk = 1'b0;
    logic               rst_n;
    logic [3:0]         btn;                            // confirm, select, exit, review
    quiz_pkg::operand_t sw;
    quiz_pkg::glyph_t   seg;
    logic [3:0]         anode;
    quiz_pkg::operand_t led_a;
    quiz_pkg::operand_t led_b;

    quiz_pkg::glyph_t digits [4];                       // last full scan
    int cycles      = 0;
    int checks      = 0;
    int errors      = 0;
    int test_errors = 0;
    int mode_now    = 1;                                // mode the console sits on

    // stimulus table with operands drawn at run time
    // a mode 2 row comes first so a stale operand b would reach a mode 1 record
    int                 row_mode [8] = '{2, 1, 1, 2, 1, 3, 4, 5};
    int                 row_op   [8] = '{0, 0, 1, 1, 2, 3, 2, 1};
    quiz_pkg::operand_t row_a    [8];
    quiz_pkg::operand_t row_b    [8];

    quiz_entry_top #(.scan_div(4)) uut (
        .clk(clk), .rst_n(rst_n),
        .confirm(btn[0]), .select(btn[1]), .exit(btn[2]), .review(btn[3]),
        .sw(sw), .seg(seg), .anode(anode), .led_a(led_a), .led_b(led_b)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: the simulation ran %0d cycles without finishing", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_eq(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic press(input int idx);
        @(negedge clk);
        btn = 4'b0001 << idx;
        repeat (3) @(negedge clk);
        btn = 4'b0000;
        repeat (6) @(negedge clk);                      // sync, control and encoder settle
    endtask

    // one pass over the four scan slots
    task automatic capture_digits;
        for (int k = 0; k < 4; k++) begin
            while (anode != (4'b0001 << k))
                @(negedge clk);
            digits[k] = seg;
        end
    endtask

    task automatic check_display(input quiz_pkg::glyph_t d0, d1, d2, d3,
                                 input quiz_pkg::operand_t la, lb, input string tag);
        capture_digits();
        check_eq(int'(digits[0]), int'(d0), {tag, " digit 0"});
        check_eq(int'(digits[1]), int'(d1), {tag, " digit 1"});
        check_eq(int'(digits[2]), int'(d2), {tag, " digit 2"});
        check_eq(int'(digits[3]), int'(d3), {tag, " digit 3"});
        check_eq(int'(led_a), int'(la), {tag, " led_a"});
        check_eq(int'(led_b), int'(lb), {tag, " led_b"});
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    function automatic quiz_pkg::glyph_t num_glyph(input int n);
        case (n)
            1:       return quiz_pkg::glyph_digit_1;
            2:       return quiz_pkg::glyph_digit_2;
            3:       return quiz_pkg::glyph_digit_3;
            4:       return quiz_pkg::glyph_digit_4;
            5:       return quiz_pkg::glyph_digit_5;
            default: return blank;
        endcase
    endfunction

    // radix letters for mode 1 and op+1 elsewhere
    function automatic quiz_pkg::glyph_t op_glyph(input int m, input int op);
        if (m != 1)
            return num_glyph(op + 1);
        case (op)
            0:       return quiz_pkg::glyph_b;
            1:       return quiz_pkg::glyph_o;
            default: return quiz_pkg::glyph_h;
        endcase
    endfunction

    function automatic int op_count(input int m);
        if (m == 1)
            return quiz_pkg::op_count_m1;
        if (m == 2)
            return quiz_pkg::op_count_m2;
        return quiz_pkg::op_count_wide;
    endfunction

    task automatic goto_mode(input int m);
        while (mode_now != m) begin
            press(btn_select);
            mode_now = (mode_now % 5) + 1;
        end
    endtask

    initial begin
        rst_n = 1'b0;
        btn   = 4'b0000;
        sw    = 8'h00;
        void'($urandom(32'hdd79271b));
        for (int i = 0; i < 8; i++) begin
            row_a[i] = 8'($urandom);
            row_b[i] = (row_mode[i] == 1) ? 8'h00 : 8'($urandom);   // radix mode has no b
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);                                 // encoder loads the idle view

        check_display(num_glyph(1), blank, blank, blank, 8'h00, 8'h00, "reset");
        end_test("reset");

        for (int i = 0; i < 5; i++) begin
            press(btn_select);
            mode_now = (mode_now % 5) + 1;
            check_display(num_glyph(mode_now), blank, blank, blank, 8'h00, 8'h00, "mode");
        end
        end_test("mode_select");

        for (int m = 1; m <= 5; m++) begin
            goto_mode(m);
            press(btn_confirm);
            check_display(num_glyph(m), num_glyph(1), blank, blank, 8'h00, 8'h00, "enter");
            for (int s = 1; s <= op_count(m); s++) begin
                press(btn_select);
                check_display(num_glyph(m), num_glyph((s % op_count(m)) + 1), blank, blank,
                              8'h00, 8'h00, "op");
            end
            press(btn_confirm);
            check_display(num_glyph(m), num_glyph(1), quiz_pkg::glyph_a, blank,
                          8'h00, 8'h00, "step a");
            if (m != 1) begin
                press(btn_confirm);                     // no write until b is taken
                check_display(num_glyph(m), num_glyph(1), quiz_pkg::glyph_a, quiz_pkg::glyph_b,
                              8'h00, 8'h00, "step b");
            end
            press(btn_exit);
            check_display(num_glyph(m), blank, blank, blank, 8'h00, 8'h00, "exit");
        end
        end_test("op_select");

        for (int i = 0; i < 8; i++) begin
            goto_mode(row_mode[i]);
            press(btn_confirm);
            repeat (row_op[i]) press(btn_select);
            press(btn_confirm);
            sw = row_a[i];
            press(btn_confirm);
            if (row_mode[i] != 1) begin
                sw = row_b[i];
                press(btn_confirm);
            end
            check_display(num_glyph(row_mode[i]), num_glyph(row_op[i] + 1), blank, blank,
                          8'h00, 8'h00, "entry");
            press(btn_exit);
        end
        end_test("entry");

        for (int i = 0; i < 8; i++) begin
            press(btn_review);
            check_display(blank, quiz_pkg::glyph_n, blank, blank, 8'h00, 8'h00, "prompt");
            sw = 8'(i + 1);                             // question numbers start at 1
            press(btn_confirm);
            check_display(num_glyph(row_mode[i]), op_glyph(row_mode[i], row_op[i]), blank, blank,
                          row_a[i], row_b[i], "review");
            press(btn_review);
        end
        end_test("review");

        press(btn_review);
        sw = 8'h00;
        press(btn_confirm);
        check_display(blank, blank, blank, blank, 8'h00, 8'h00, "number 0");
        press(btn_confirm);
        sw = 8'd9;                                      // one past the stored count
        press(btn_confirm);
        check_display(blank, blank, blank, blank, 8'h00, 8'h00, "number 9");
        press(btn_review);
        end_test("invalid");

        check_eq(uut.u_assertions.fail_cnt, 0, "assertion failures");
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule
